// File: dataCache.f
design/cachePkg.sv
design/cacheFsm.sv
design/cacheAdrSelect.sv
design/cacheWay.sv
design/cacheWayCombine.sv
design/cacheApbMover.sv
design/dataCache.sv
bench/apbMemory.sv
bench/dataCache_asserts.sv
bench/dataCacheTb.sv

// File: Makefile
# Verilator build and run of the data cache testbench
# any variable can be overridden, e.g. make test LOG=run2.log

VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= dataCache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, fail on a failed check"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/dataCacheTb.sv
`timescale 1ns/1ns
/*
  Random CPU traffic over a 3-tag window (byte addresses 0 to 0x2FF) against a
  word model of memory. Inputs change 1 ns after the rising edge, outputs are
  sampled at the falling edge.
*/
module dataCacheTb;

  // a flush may write back every line of every way, about 24 cycles each
  localparam int RequestLimit = 200;
  localparam int FlushLimit   = 1000;

  logic clk = 1'b0;
  logic reset, read, write, flush;
  cachePkg::cacheAdrT adr;
  logic [31:0] writeData, readData, paddr, pwdata, prdata;
  logic stall, psel, penable, pwrite, pready;

  logic [31:0] model [192];
  logic        written [192];
  int testChecks, testErrors, totalChecks, totalErrors, numTests;
  logic [31:0] a, otherAdr, prevAdr;
  logic        prevRead;
  int          waited, setSel;

  dataCache #(.NumWays(2)) dut (.*);

  apbMemory mem (.*);

  always #2 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] initWord(input logic [31:0] byteAdr);
    return (byteAdr * 32'h9e3779b1) ^ 32'hc3a55a3c;
  endfunction

  function automatic logic [31:0] randomAdr();
    return 32'($urandom_range(191, 0)) << 2;
  endfunction

  task automatic checkEqual(input string sig, input logic [31:0] at,
                            input logic [31:0] got, input logic [31:0] exp);
    testChecks++;
    assert (got === exp) else begin
      $display("FAIL %s at adr %h: got %h expected %h", sig, at, got, exp);
      testErrors++;
    end
  endtask

  // counts the stalled cycles before the completing edge
  task automatic waitForCompletion(input string what, input logic [31:0] at,
                                   input int limit,
                                   output logic [31:0] rd, output int stalled);
    logic done;
    done    = 1'b0;
    stalled = 0;
    rd      = '0;
    while (!done && stalled < limit) begin
      @(negedge clk);
      if (!stall) begin
        done = 1'b1;
        rd   = readData;
      end else begin
        stalled++;
      end
      @(posedge clk);
    end
    #1;
    assert (done) else begin
      $display("timeout: stall stayed high for %0d cycles on %s at adr %h", limit, what, at);
      testErrors++;
    end
  endtask

  task automatic writeWord(input logic [31:0] at, input logic [31:0] data);
    logic [31:0] rd;
    int          stalled;
    write     = 1'b1;
    adr.flat  = at;
    writeData = data;
    waitForCompletion("write", at, RequestLimit, rd, stalled);
    write = 1'b0;
    model[at[9:2]]   = data;
    written[at[9:2]] = 1'b1;
  endtask

  task automatic readAndCheck(input logic [31:0] at, output int stalled);
    logic [31:0] rd;
    read     = 1'b1;
    adr.flat = at;
    waitForCompletion("read", at, RequestLimit, rd, stalled);
    read = 1'b0;
    checkEqual("readData", at, rd, model[at[9:2]]);
  endtask

  task automatic flushCache();
    logic [31:0] rd;
    int          stalled;
    flush = 1'b1;
    waitForCompletion("flush", 32'h0, FlushLimit, rd, stalled);
    flush = 1'b0;
  endtask

  task automatic endTest(input string name);
    $display("test %s: %0d checks, %0d errors", name, testChecks, testErrors);
    totalChecks += testChecks;
    totalErrors += testErrors;
    testChecks = 0;
    testErrors = 0;
    numTests++;
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    reset     = 1'b1;
    read      = 1'b0;
    write     = 1'b0;
    flush     = 1'b0;
    adr       = '0;
    writeData = '0;
    void'($urandom(32'h4391ca0f));
    for (int i = 0; i < 192; i++) begin
      model[i]   = initWord(32'(i) << 2);
      written[i] = 1'b0;
    end
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;

    @(negedge clk);
    checkEqual("stall", 32'h0, 32'(stall), 32'h0);
    checkEqual("psel", 32'h0, 32'(psel), 32'h0);
    checkEqual("penable", 32'h0, 32'(penable), 32'h0);
    @(posedge clk);
    #1;
    for (int i = 0; i < 8; i++) begin
      readAndCheck(randomAdr(), waited);
    end
    endTest("reset state and first reads");

    // second half evicts the written line with the two other tags of its set
    for (int i = 0; i < 20; i++) begin
      a = randomAdr();
      writeWord(a, $urandom);
      readAndCheck(a, waited);
    end
    for (int i = 0; i < 10; i++) begin
      a = randomAdr();
      writeWord(a, $urandom);
      for (int t = 1; t < 3; t++) begin
        otherAdr = ((((a >> 8) + 32'(t)) % 3) << 8) | (a & 32'hff);
        writeWord(otherAdr, $urandom);
      end
      readAndCheck(a, waited);
    end
    endTest("read after write");

    for (int i = 0; i < 20; i++) begin
      a = randomAdr();
      readAndCheck(a, waited);
      readAndCheck(a, waited);
      checkEqual("stall cycles", a, 32'(waited), 32'h0);
    end
    endTest("read hit latency");

    setSel = $urandom_range(15, 0);
    for (int r = 0; r < 4; r++) begin
      for (int t = 0; t < 3; t++) begin
        for (int w = 0; w < 4; w++) begin
          writeWord(32'((t << 8) | (setSel << 4) | (w << 2)), $urandom);
        end
      end
    end
    for (int t = 0; t < 3; t++) begin
      for (int w = 0; w < 4; w++) begin
        readAndCheck(32'((t << 8) | (setSel << 4) | (w << 2)), waited);
      end
    end
    endTest("conflict evictions");

    prevRead = 1'b0;
    prevAdr  = '0;
    for (int i = 0; i < 2000; i++) begin
      a = randomAdr();
      if ($urandom_range(1, 0) == 1) begin
        writeWord(a, $urandom);
        prevRead = 1'b0;
      end else begin
        readAndCheck(a, waited);
        if (prevRead && a == prevAdr) begin
          checkEqual("stall cycles", a, 32'(waited), 32'h0);
        end
        prevRead = 1'b1;
      end
      prevAdr = a;
    end
    endTest("random mix with APB wait states");

    flushCache();
    for (int i = 0; i < 192; i++) begin
      if (written[i]) begin
        checkEqual("mem.store", 32'(i) << 2, mem.store[i], model[i]);
      end
    end
    endTest("flush write-back");

    $display("%0d tests, %0d checks, %0d errors", numTests, totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: bench/dataCache_asserts.sv
`timescale 1ns/1ns
/*
  Protocol and controller properties, bound into every dataCache instance.
*/
module dataCacheAsserts (
  input logic                 clk,
  input logic                 reset,
  input logic                 read,
  input logic                 write,
  input logic                 flush,
  input logic                 stall,
  input logic                 fetchLine,
  input logic                 writeLine,
  input logic                 psel,
  input logic                 penable,
  input logic                 pready,
  input logic [31:0]          paddr,
  input cachePkg::cacheStateT state
);
  import cachePkg::*;

  // a stretched access phase keeps the bus and the address
  apbHold: assert property (@(posedge clk) disable iff (reset)
    (psel && penable && !pready) |=> (psel && penable && $stable(paddr)))
    else $error("APB access phase dropped or paddr moved before pready");

  oneStart: assert property (@(posedge clk) disable iff (reset)
    !(fetchLine && writeLine))
    else $error("fetchLine and writeLine fired in the same cycle");

  idleReady: assert property (@(posedge clk) disable iff (reset)
    (state == stReady && !read && !write && !flush) |-> !stall)
    else $error("stall high in the ready state with no request");

endmodule

bind dataCache dataCacheAsserts asserts (.*);

// File: bench/apbMemory.sv
`timescale 1ns/1ns
/*
  APB completer memory of 256 words, byte addresses 0 to 0x3FF. Every beat gets
  0 to 3 wait states from $urandom. store can be read directly as a backdoor.
*/
module apbMemory (
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready
);
  logic [31:0] store [256];
  logic [1:0]  waitLeft;

  // fill pattern from the byte address of each word
  initial begin
    for (int i = 0; i < 256; i++) begin
      store[i] = ((32'(i) << 2) * 32'h9e3779b1) ^ 32'hc3a55a3c;
    end
  end

  // wait states are drawn in the setup phase and counted down in the access phase
  always_ff @(posedge clk) begin
    if (reset) begin
      waitLeft <= 2'd0;
    end else if (psel && !penable) begin
      waitLeft <= 2'($urandom_range(3, 0));
    end else if (psel && penable && waitLeft != 2'd0) begin
      waitLeft <= waitLeft - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (psel && penable && pready && pwrite) begin
      store[paddr[9:2]] <= pwdata;
    end
  end

  assign pready = psel && penable && (waitLeft == 2'd0);
  assign prdata = store[paddr[9:2]];

endmodule

// File: design/dataCache.sv
`timescale 1ns/1ns
/*
  Write-back set-associative L1 data cache, whole-word accesses only.
  NumWays is 2 or 4. Lines are filled and written back over APB.
*/
module dataCache #(
  parameter int NumWays = 2
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            read,
  input  logic                            write,
  input  logic                            flush,
  input  cachePkg::cacheAdrT              adr,
  input  logic [cachePkg::WordBits-1:0]   writeData,
  output logic [cachePkg::WordBits-1:0]   readData,
  output logic                            stall,
  output logic                            psel,
  output logic                            penable,
  output logic                            pwrite,
  output logic [cachePkg::AdrBits-1:0]    paddr,
  output logic [cachePkg::WordBits-1:0]   pwdata,
  input  logic [cachePkg::WordBits-1:0]   prdata,
  input  logic                            pready
);
  import cachePkg::*;

  localparam int WayBits = $clog2(NumWays);

  logic hit, victimDirty, busAck, flushSetLast, flushWayLast;
  logic fetchLine, writeLine, lineWriteEn, wordWriteEn, clearDirty;
  logic selEvict, selFlush, flushSetEn, flushWayEn, flushSetRst, flushWayRst;
  cacheStateT state;

  logic [IndexBits-1:0] index;
  logic [TagBits-1:0]   lookupTag;
  logic [TagBits-1:0]   victimTag;
  logic [WayBits-1:0]   flushWay;
  cacheAdrT             busAdr;
  lineT                 victimLine;
  lineT                 fetchedLine;

  logic [NumWays-1:0] wayHit, wayDirty, wayWriteLine, wayWriteWord, wayClearDirty;
  logic [TagBits-1:0] wayTag  [NumWays];
  lineT               wayLine [NumWays];

  cacheFsm fsm (.*);

  cacheAdrSelect #(.NumWays(NumWays)) adrSelect (.*);

  cacheWayCombine #(.NumWays(NumWays)) wayCombine (
    .*,
    .wordOffset (adr.fields.wordOffset)
  );

  cacheApbMover mover (.*);

  for (genvar g = 0; g < NumWays; g++) begin : gWay
    cacheWay way (
      .clk           (clk),
      .reset         (reset),
      .index         (index),
      .lookupTag     (lookupTag),
      .wordOffset    (adr.fields.wordOffset),
      .writeData     (writeData),
      .fillLine      (fetchedLine),
      .fillTag       (adr.fields.tag),
      .wayWriteLine  (wayWriteLine[g]),
      .wayWriteWord  (wayWriteWord[g]),
      .wayClearDirty (wayClearDirty[g]),
      .wayHit        (wayHit[g]),
      .wayDirty      (wayDirty[g]),
      .wayTag        (wayTag[g]),
      .wayLine       (wayLine[g])
    );
  end

endmodule

// File: design/cacheApbMover.sv
`timescale 1ns/1ns
/*
  APB requester moving one line in LineWords beats. busAdr and victimLine must hold
  for the whole transfer. busAck pulses one cycle after the last beat.
*/
module cacheApbMover (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            fetchLine,
  input  logic                            writeLine,
  input  cachePkg::cacheAdrT              busAdr,
  input  cachePkg::lineT                  victimLine,
  input  logic [cachePkg::WordBits-1:0]   prdata,
  input  logic                            pready,
  output logic                            psel,
  output logic                            penable,
  output logic                            pwrite,
  output logic [cachePkg::AdrBits-1:0]    paddr,
  output logic [cachePkg::WordBits-1:0]   pwdata,
  output logic                            busAck,
  output cachePkg::lineT                  fetchedLine
);
  import cachePkg::*;

  logic [WordSelBits-1:0] beat;
  logic                   beatDone;

  assign beatDone = psel & penable & pready;

  ////////////////////
  // two-phase APB sequencing
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      beat    <= '0;
      busAck  <= 1'b0;
    end else begin
      busAck <= 1'b0;
      if (!psel) begin
        if (fetchLine | writeLine) begin
          psel   <= 1'b1;
          pwrite <= writeLine;
          beat   <= '0;
        end
      end else if (!penable) begin
        penable <= 1'b1;
      end else if (pready) begin
        // back to setup for the next beat, or release the bus after the last
        penable <= 1'b0;
        beat    <= beat + 1'b1;
        if (beat == WordSelBits'(LineWords - 1)) begin
          psel   <= 1'b0;
          busAck <= 1'b1;
        end
      end
    end
  end

  // line buffer for the controller's fill
  always_ff @(posedge clk) begin
    if (beatDone & ~pwrite) begin
      fetchedLine[beat] <= prdata;
    end
  end

  assign paddr  = busAdr.flat + AdrBits'({beat, {ByteSelBits{1'b0}}});
  assign pwdata = victimLine[beat];

endmodule

// File: design/cacheWayCombine.sv
`timescale 1ns/1ns
/*
  Merges the ways into hit, read data and victim information and steers the write
  enables. Replacement is round-robin per set, advanced on every line fill.
*/
module cacheWayCombine #(
  parameter int NumWays = 2
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [NumWays-1:0]                 wayHit,
  input  logic [NumWays-1:0]                 wayDirty,
  input  logic [cachePkg::TagBits-1:0]       wayTag [NumWays],
  input  cachePkg::lineT                     wayLine [NumWays],
  input  logic [cachePkg::IndexBits-1:0]     index,
  input  logic [cachePkg::WordSelBits-1:0]   wordOffset,
  input  logic                               selFlush,
  input  logic [$clog2(NumWays)-1:0]         flushWay,
  input  logic                               lineWriteEn,
  input  logic                               wordWriteEn,
  input  logic                               clearDirty,
  output logic                               hit,
  output logic [cachePkg::WordBits-1:0]      readData,
  output logic                               victimDirty,
  output logic [cachePkg::TagBits-1:0]       victimTag,
  output cachePkg::lineT                     victimLine,
  output logic [NumWays-1:0]                 wayWriteLine,
  output logic [NumWays-1:0]                 wayWriteWord,
  output logic [NumWays-1:0]                 wayClearDirty
);
  import cachePkg::*;

  localparam int WayBits = $clog2(NumWays);

  logic [WayBits-1:0] rrPtr [NumSets];
  logic [WayBits-1:0] victim;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NumSets; s++) begin
        rrPtr[s] <= '0;
      end
    end else if (lineWriteEn) begin
      rrPtr[index] <= rrPtr[index] + 1'b1;
    end
  end

  assign victim      = selFlush ? flushWay : rrPtr[index];
  assign victimDirty = wayDirty[victim];
  assign victimTag   = wayTag[victim];
  assign victimLine  = wayLine[victim];

  // at most one way hits, so an OR of the gated words is the read mux
  always_comb begin
    readData = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (wayHit[w]) begin
        readData = readData | wayLine[w][wordOffset];
      end
    end
  end

  assign hit          = |wayHit;
  assign wayWriteWord = {NumWays{wordWriteEn}} & wayHit;

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayWriteLine[w]  = lineWriteEn & (victim == WayBits'(w));
      wayClearDirty[w] = clearDirty & (victim == WayBits'(w));
    end
  end

endmodule

// File: design/cacheWay.sv
`timescale 1ns/1ns
/*
  One cache way: valid, dirty, tag and line arrays with a hit compare.
  Reads are combinational. Only valid and dirty are cleared by reset.
*/
module cacheWay (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [cachePkg::IndexBits-1:0]     index,
  input  logic [cachePkg::TagBits-1:0]       lookupTag,
  input  logic [cachePkg::WordSelBits-1:0]   wordOffset,
  input  logic [cachePkg::WordBits-1:0]      writeData,
  input  cachePkg::lineT                     fillLine,
  input  logic [cachePkg::TagBits-1:0]       fillTag,
  input  logic                               wayWriteLine,
  input  logic                               wayWriteWord,
  input  logic                               wayClearDirty,
  output logic                               wayHit,
  output logic                               wayDirty,
  output logic [cachePkg::TagBits-1:0]       wayTag,
  output cachePkg::lineT                     wayLine
);
  import cachePkg::*;

  logic [NumSets-1:0] valid;
  logic [NumSets-1:0] dirty;
  logic [TagBits-1:0] tags  [NumSets];
  lineT               lines [NumSets];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (wayWriteLine) begin
      // a fresh fill matches memory
      valid[index] <= 1'b1;
      dirty[index] <= 1'b0;
    end else if (wayWriteWord) begin
      dirty[index] <= 1'b1;
    end else if (wayClearDirty) begin
      dirty[index] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wayWriteLine) begin
      tags[index]  <= fillTag;
      lines[index] <= fillLine;
    end else if (wayWriteWord) begin
      lines[index][wordOffset] <= writeData;
    end
  end

  assign wayTag   = tags[index];
  assign wayLine  = lines[index];
  assign wayDirty = valid[index] & dirty[index];
  assign wayHit   = valid[index] & (tags[index] == lookupTag);

endmodule

// File: design/cacheAdrSelect.sv
`timescale 1ns/1ns
/*
  Array index and bus line address selection, plus the flush set and way counters.
  NumWays must be a power of two.
*/
module cacheAdrSelect #(
  parameter int NumWays = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  cachePkg::cacheAdrT                adr,
  input  logic [cachePkg::TagBits-1:0]      victimTag,
  input  logic                              selEvict,
  input  logic                              selFlush,
  input  logic                              flushSetEn,
  input  logic                              flushWayEn,
  input  logic                              flushSetRst,
  input  logic                              flushWayRst,
  output logic [cachePkg::IndexBits-1:0]    index,
  output logic [cachePkg::TagBits-1:0]      lookupTag,
  output logic [$clog2(NumWays)-1:0]        flushWay,
  output logic                              flushSetLast,
  output logic                              flushWayLast,
  output cachePkg::cacheAdrT                busAdr
);
  import cachePkg::*;

  localparam int WayBits = $clog2(NumWays);

  logic [IndexBits-1:0] flushSet;

  ////////////////////
  // flush walk counters
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset | flushSetRst) begin
      flushSet <= '0;
    end else if (flushSetEn) begin
      flushSet <= flushSet + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset | flushWayRst) begin
      flushWay <= '0;
    end else if (flushWayEn) begin
      flushWay <= flushWay + 1'b1;
    end
  end

  assign flushSetLast = (flushSet == IndexBits'(NumSets - 1));
  assign flushWayLast = (flushWay == WayBits'(NumWays - 1));

  assign index     = selFlush ? flushSet : adr.fields.index;
  assign lookupTag = adr.fields.tag;

  // line base address: write-backs go to the victim's home, fetches to the request's
  always_comb begin
    busAdr                   = '0;
    busAdr.fields.tag        = (selEvict | selFlush) ? victimTag : adr.fields.tag;
    busAdr.fields.index      = index;
  end

endmodule

// File: design/cacheFsm.sv
`timescale 1ns/1ns
/*
  Cache controller. The CPU holds read, write, flush and adr until it sees stall low
  at a rising edge. read and write are never both high, and flush wins over both.
*/
module cacheFsm (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 read,
  input  logic                 write,
  input  logic                 flush,
  input  logic                 hit,
  input  logic                 victimDirty,
  input  logic                 busAck,
  input  logic                 flushSetLast,
  input  logic                 flushWayLast,
  output logic                 stall,
  output logic                 fetchLine,
  output logic                 writeLine,
  output logic                 lineWriteEn,
  output logic                 wordWriteEn,
  output logic                 clearDirty,
  output logic                 selEvict,
  output logic                 selFlush,
  output logic                 flushSetEn,
  output logic                 flushWayEn,
  output logic                 flushSetRst,
  output logic                 flushWayRst,
  output cachePkg::cacheStateT state
);
  import cachePkg::*;

  cacheStateT nextState;
  logic       access;
  logic       anyMiss;
  logic       flushDone;
  logic       setStep;
  logic       walkStep;

  assign access    = (read | write) & ~flush;
  assign anyMiss   = access & ~hit;
  assign flushDone = flushSetLast & flushWayLast;
  assign setStep   = flushWayLast & ~flushSetLast;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    nextState = state;
    case (state)
      stReady:
        if (flush)
          nextState = stFlushStart;
        else if (anyMiss)
          nextState = stFetchWait;
      stFetchWait:
        if (busAck)
          nextState = stFetchDone;
      // evict only when the line we are about to replace holds new data
      stFetchDone:
        nextState = victimDirty ? stEvictDirty : stWriteLine;
      stEvictDirty:
        if (busAck)
          nextState = stWriteLine;
      stWriteLine:
        nextState = stReady;
      stFlushStart:
        nextState = stFlushCheck;
      stFlushCheck:
        if (victimDirty)
          nextState = stFlushWriteBack;
        else if (flushDone)
          nextState = stReady;
        else if (flushWayLast)
          nextState = stFlushIncr;
      stFlushIncr:
        nextState = stFlushCheck;
      stFlushWriteBack:
        if (busAck)
          nextState = stFlushClearDirty;
      stFlushClearDirty:
        if (flushDone)
          nextState = stReady;
        else if (flushWayLast)
          nextState = stFlushIncr;
        else
          nextState = stFlushCheck;
      default:
        nextState = stReady;
    endcase
  end

  ////////////////////
  // outputs
  ////////////////////
  always_comb begin
    case (state)
      stReady:           stall = flush | anyMiss;
      stFlushCheck:      stall = victimDirty | ~flushDone;
      stFlushClearDirty: stall = ~flushDone;
      default:           stall = 1'b1;
    endcase
  end

  assign fetchLine   = (state == stReady) & anyMiss;
  assign writeLine   = ((state == stFetchDone) | (state == stFlushCheck)) & victimDirty;
  assign lineWriteEn = (state == stWriteLine);
  assign wordWriteEn = (state == stReady) & access & write & hit;
  assign clearDirty  = (state == stFlushClearDirty);

  assign selEvict = (state == stEvictDirty);
  assign selFlush = (state == stFlushStart) | (state == stFlushCheck) |
                    (state == stFlushIncr) | (state == stFlushWriteBack) |
                    (state == stFlushClearDirty);

  // the walk moves on after a clean check or after clearing a written-back line
  assign walkStep    = ((state == stFlushCheck) & ~victimDirty) | (state == stFlushClearDirty);
  assign flushSetEn  = walkStep & setStep;
  assign flushWayEn  = walkStep & ~flushDone;
  assign flushSetRst = (state == stReady);
  assign flushWayRst = (state == stReady) | (state == stFlushIncr);

endmodule

// File: design/cachePkg.sv
/*
  Shared sizes and types of the L1 data cache. Line size and set count are fixed
  here. The way count is a module parameter of the top level.
*/
package cachePkg;

  localparam int WordBits    = 32;
  localparam int AdrBits     = 32;
  localparam int LineWords   = 4;
  localparam int NumSets     = 16;
  localparam int ByteSelBits = 2;
  localparam int WordSelBits = $clog2(LineWords);
  localparam int IndexBits   = $clog2(NumSets);
  localparam int TagBits     = AdrBits - IndexBits - WordSelBits - ByteSelBits;

  // one address word, seen flat by the bus side and as fields by the arrays
  typedef union packed {
    logic [AdrBits-1:0] flat;
    struct packed {
      logic [TagBits-1:0]     tag;
      logic [IndexBits-1:0]   index;
      logic [WordSelBits-1:0] wordOffset;
      logic [ByteSelBits-1:0] byteOffset;
    } fields;
  } cacheAdrT;

  typedef logic [LineWords-1:0][WordBits-1:0] lineT;

  typedef enum logic [3:0] {
    stReady, stFetchWait, stFetchDone, stEvictDirty, stWriteLine,
    stFlushStart, stFlushCheck, stFlushIncr, stFlushWriteBack, stFlushClearDirty
  } cacheStateT;

endpackage
